/* common/fetch_params.svh */
// instruction fetch memory parameters: widths, cache geometry and AXI read codes
`ifndef FETCH_PARAMS_SVH
`define FETCH_PARAMS_SVH

// byte address width
`define FETCH_ADDR_W 32

// cache geometry, 8 lines of 16 bytes
`define FETCH_INDEX_W 3
`define FETCH_OFFSET_W 4

// AXI arsize code for 4-byte beats
`define AXI_SIZE_4 3'd2

// AXI arburst code for incrementing bursts
`define AXI_BURST_INCR 2'd1

// uncached device and boot region served by the I/O port
`define FETCH_IO_BASE 32'h1000_0000
`define FETCH_IO_LIMIT 32'h1000_FFFF

`endif

/* common/fetch_pkg.sv */
// shared word, address and AXI read channel types for the fetch memory subsystem
`include "fetch_params.svh"

package fetch_pkg;

	// one instruction or data word
	typedef logic [31:0] word_t;

	// byte address
	typedef logic [`FETCH_ADDR_W-1:0] addr_t;

	// one read address request
	typedef struct packed {
		addr_t addr;
		logic [7:0] len;
		logic [2:0] size;
		logic [1:0] burst;
	} ar_req_t;

	// one read data beat
	typedef struct packed {
		word_t data;
		logic last;
	} r_beat_t;

endpackage

/* icache/icache.sv */
// direct-mapped instruction cache with burst refill and fence.i invalidate
`timescale 1ns/1ns
`include "fetch_params.svh"

module icache (
	input logic clock,
	input logic reset,
	input fetch_pkg::addr_t paddr,
	input logic psel,
	input logic fence_flag,
	output logic pready,
	output fetch_pkg::word_t prdata,
	output logic arvalid,
	output fetch_pkg::ar_req_t ar,
	input logic arready,
	input logic rvalid,
	input fetch_pkg::r_beat_t r,
	output logic rready
);

	localparam int TAG_W = `FETCH_ADDR_W - `FETCH_INDEX_W - `FETCH_OFFSET_W;
	localparam int LINES = 1 << `FETCH_INDEX_W;
	localparam int BEATS = (1 << `FETCH_OFFSET_W) / 4;
	localparam int LINE_W = BEATS * 32;
	localparam int WSEL_W = `FETCH_OFFSET_W - 2;

	typedef enum logic [2:0] {
		S_IDLE,
		S_CHECK,
		S_ADDR,
		S_LOAD,
		S_UPDATE,
		S_PASS,
		S_FENCE
	} state_t;

	state_t state;
	state_t next_state;

	// line storage, tags and per-line valid bits
	logic [LINE_W-1:0] data_mem [LINES];
	logic [TAG_W-1:0] tag_mem [LINES];
	logic [LINES-1:0] valid;

	// refill assembly buffer
	logic [LINE_W-1:0] line_buf;

	logic [TAG_W-1:0] addr_tag;
	logic [`FETCH_INDEX_W-1:0] addr_index;
	logic [WSEL_W-1:0] word_sel;
	logic [LINE_W-1:0] line_word;
	logic hit;

	assign addr_tag = paddr[`FETCH_ADDR_W-1:`FETCH_INDEX_W+`FETCH_OFFSET_W];
	assign addr_index = paddr[`FETCH_INDEX_W+`FETCH_OFFSET_W-1:`FETCH_OFFSET_W];
	assign word_sel = paddr[`FETCH_OFFSET_W-1:2];

	assign hit = valid[addr_index] && (tag_mem[addr_index] == addr_tag);

	always_comb begin
		next_state = state;
		case (state)
			S_IDLE: begin
				if (psel) begin
					next_state = S_CHECK;
				end else if (fence_flag) begin
					next_state = S_FENCE;
				end
			end
			S_CHECK: begin
				next_state = hit ? S_PASS : S_ADDR;
			end
			S_ADDR: begin
				if (arready) begin
					next_state = S_LOAD;
				end
			end
			S_LOAD: begin
				// last beat of the refill burst
				if (rvalid && r.last) begin
					next_state = S_UPDATE;
				end
			end
			S_UPDATE: begin
				next_state = S_PASS;
			end
			S_PASS: begin
				// back-to-back request goes straight to check
				next_state = psel ? S_CHECK : S_IDLE;
			end
			S_FENCE: begin
				next_state = S_IDLE;
			end
			default: begin
				next_state = S_IDLE;
			end
		endcase
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= S_IDLE;
		end else begin
			state <= next_state;
		end
	end

	// beats arrive lowest word first and shift down into place
	always_ff @(posedge clock) begin
		if (state == S_LOAD && rvalid) begin
			line_buf <= {r.data, line_buf[LINE_W-1:32]};
		end
	end

	always_ff @(posedge clock) begin
		if (state == S_UPDATE) begin
			data_mem[addr_index] <= line_buf;
			tag_mem[addr_index] <= addr_tag;
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			valid <= '0;
		end else if (state == S_IDLE && next_state == S_FENCE) begin
			valid <= '0;
		end else if (state == S_UPDATE) begin
			valid[addr_index] <= 1'b1;
		end
	end

	assign line_word = data_mem[addr_index];
	assign prdata = line_word[{word_sel, 5'b0} +: 32];

	// line-aligned refill burst
	always_comb begin
		ar.addr = {addr_tag, addr_index, {`FETCH_OFFSET_W{1'b0}}};
		ar.len = 8'(BEATS - 1);
		ar.size = `AXI_SIZE_4;
		ar.burst = `AXI_BURST_INCR;
	end

	assign arvalid = (state == S_ADDR);
	assign rready = (state == S_LOAD);
	assign pready = (state == S_PASS);

endmodule

/* rtl/uncached_fetch.sv */
// uncached single-word reader for device and boot memory on the I/O port
`timescale 1ns/1ns
`include "fetch_params.svh"

module uncached_fetch (
	input logic clock,
	input logic reset,
	input logic psel,
	input fetch_pkg::addr_t paddr,
	output logic pready,
	output fetch_pkg::word_t prdata,
	output logic arvalid,
	output fetch_pkg::ar_req_t ar,
	input logic arready,
	input logic rvalid,
	input fetch_pkg::r_beat_t r,
	output logic rready
);

	typedef enum logic [1:0] {
		S_IDLE,
		S_ADDR,
		S_DATA,
		S_RESP
	} state_t;

	state_t state;

	// captured read data
	fetch_pkg::word_t data_q;

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= S_IDLE;
		end else begin
			case (state)
				S_IDLE: if (psel) state <= S_ADDR;
				S_ADDR: if (arready) state <= S_DATA;
				S_DATA: if (rvalid) state <= S_RESP;
				default: state <= S_IDLE;
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (state == S_DATA && rvalid) begin
			data_q <= r.data;
		end
	end

	// single beat at the word-aligned address
	always_comb begin
		ar.addr = {paddr[`FETCH_ADDR_W-1:2], 2'b00};
		ar.len = 8'd0;
		ar.size = `AXI_SIZE_4;
		ar.burst = `AXI_BURST_INCR;
	end

	assign arvalid = (state == S_ADDR);
	assign rready = (state == S_DATA);
	assign pready = (state == S_RESP);
	assign prdata = data_q;

endmodule

/* rtl/axi_read_arbiter.sv */
// round-robin AXI read arbiter that locks the memory port for a whole burst
`timescale 1ns/1ns

module axi_read_arbiter (
	input logic clock,
	input logic reset,
	// client 0
	input logic c0_arvalid,
	input fetch_pkg::ar_req_t c0_ar,
	output logic c0_arready,
	output logic c0_rvalid,
	output fetch_pkg::r_beat_t c0_r,
	input logic c0_rready,
	// client 1
	input logic c1_arvalid,
	input fetch_pkg::ar_req_t c1_ar,
	output logic c1_arready,
	output logic c1_rvalid,
	output fetch_pkg::r_beat_t c1_r,
	input logic c1_rready,
	// memory side
	output logic m_arvalid,
	output fetch_pkg::ar_req_t m_ar,
	input logic m_arready,
	input logic m_rvalid,
	input fetch_pkg::r_beat_t m_r,
	output logic m_rready
);

	logic busy;
	logic owner;
	logic last_served;
	logic pick;
	logic grant;
	logic burst_done;

	// on a tie the client not served last time wins
	always_comb begin
		if (c0_arvalid && c1_arvalid) begin
			pick = ~last_served;
		end else begin
			pick = c1_arvalid;
		end
	end

	// grant follows pick while idle so no cycle is lost
	assign grant = busy ? owner : pick;

	assign burst_done = busy && m_rvalid && m_rready && m_r.last;

	always_ff @(posedge clock) begin
		if (reset) begin
			busy <= 1'b0;
			owner <= 1'b0;
			last_served <= 1'b1;
		end else if (!busy) begin
			if (c0_arvalid || c1_arvalid) begin
				busy <= 1'b1;
				owner <= pick;
				last_served <= pick;
			end
		end else if (burst_done) begin
			busy <= 1'b0;
		end
	end

	// address channel toward memory
	assign m_arvalid = grant ? c1_arvalid : c0_arvalid;
	assign m_ar = grant ? c1_ar : c0_ar;
	assign c0_arready = m_arready && !grant;
	assign c1_arready = m_arready && grant;

	// data beats back to the owner only
	assign c0_rvalid = m_rvalid && busy && !owner;
	assign c1_rvalid = m_rvalid && busy && owner;
	assign c0_r = (busy && !owner) ? m_r : '0;
	assign c1_r = (busy && owner) ? m_r : '0;

	always_comb begin
		if (!busy) begin
			m_rready = 1'b0;
		end else begin
			m_rready = owner ? c1_rready : c0_rready;
		end
	end

endmodule

/* rtl/fetch_mem_top.sv */
// instruction memory side: fetch cache and uncached I/O reader sharing one AXI read master
`timescale 1ns/1ns

module fetch_mem_top (
	input logic clock,
	input logic reset,
	// fetch port
	input fetch_pkg::addr_t fetch_paddr,
	input logic fetch_psel,
	input logic fetch_fence,
	output logic fetch_pready,
	output fetch_pkg::word_t fetch_prdata,
	// I/O port
	input fetch_pkg::addr_t io_paddr,
	input logic io_psel,
	output logic io_pready,
	output fetch_pkg::word_t io_prdata,
	// memory read master
	output logic m_arvalid,
	output fetch_pkg::ar_req_t m_ar,
	input logic m_arready,
	input logic m_rvalid,
	input fetch_pkg::r_beat_t m_r,
	output logic m_rready
);

	logic ic_arvalid;
	fetch_pkg::ar_req_t ic_ar;
	logic ic_arready;
	logic ic_rvalid;
	fetch_pkg::r_beat_t ic_r;
	logic ic_rready;

	logic io_arvalid;
	fetch_pkg::ar_req_t io_ar;
	logic io_arready;
	logic io_rvalid;
	fetch_pkg::r_beat_t io_r;
	logic io_rready;

	icache u_icache (
		.clock(clock),
		.reset(reset),
		.paddr(fetch_paddr),
		.psel(fetch_psel),
		.fence_flag(fetch_fence),
		.pready(fetch_pready),
		.prdata(fetch_prdata),
		.arvalid(ic_arvalid),
		.ar(ic_ar),
		.arready(ic_arready),
		.rvalid(ic_rvalid),
		.r(ic_r),
		.rready(ic_rready)
	);

	uncached_fetch u_uncached_fetch (
		.clock(clock),
		.reset(reset),
		.psel(io_psel),
		.paddr(io_paddr),
		.pready(io_pready),
		.prdata(io_prdata),
		.arvalid(io_arvalid),
		.ar(io_ar),
		.arready(io_arready),
		.rvalid(io_rvalid),
		.r(io_r),
		.rready(io_rready)
	);

	// cache is client 0
	axi_read_arbiter u_axi_read_arbiter (
		.clock(clock),
		.reset(reset),
		.c0_arvalid(ic_arvalid),
		.c0_ar(ic_ar),
		.c0_arready(ic_arready),
		.c0_rvalid(ic_rvalid),
		.c0_r(ic_r),
		.c0_rready(ic_rready),
		.c1_arvalid(io_arvalid),
		.c1_ar(io_ar),
		.c1_arready(io_arready),
		.c1_rvalid(io_rvalid),
		.c1_r(io_r),
		.c1_rready(io_rready),
		.m_arvalid(m_arvalid),
		.m_ar(m_ar),
		.m_arready(m_arready),
		.m_rvalid(m_rvalid),
		.m_r(m_r),
		.m_rready(m_rready)
	);

endmodule

/* testbench/axi_mem_model.sv */
// AXI read slave model with address-derived data and random handshake stalls
`timescale 1ns/1ns

module axi_mem_model (
	input logic clock,
	input logic reset,
	input logic arvalid,
	input fetch_pkg::ar_req_t ar,
	output logic arready,
	output logic rvalid,
	output fetch_pkg::r_beat_t r,
	input logic rready
);

	integer seed = 32'h4336;

	logic busy;
	fetch_pkg::addr_t addr_q;
	logic [7:0] beats_left;

	// ready or valid about three cycles out of four
	function automatic logic ready_draw();
		ready_draw = ($random(seed) & 3) != 0;
	endfunction

	// word at a byte address is the aligned address with the upper pattern flipped
	assign r.data = {addr_q[31:2], 2'b00} ^ 32'h5A5A_0000;
	assign r.last = busy && (beats_left == 8'd0);

	always @(posedge clock) begin
		if (reset) begin
			arready <= 1'b0;
			rvalid <= 1'b0;
			busy <= 1'b0;
			addr_q <= '0;
			beats_left <= '0;
		end else if (!busy) begin
			if (arvalid && arready) begin
				busy <= 1'b1;
				arready <= 1'b0;
				addr_q <= ar.addr;
				beats_left <= ar.len;
				rvalid <= ready_draw();
			end else begin
				arready <= ready_draw();
			end
		end else if (rvalid && rready) begin
			if (beats_left == 8'd0) begin
				busy <= 1'b0;
				rvalid <= 1'b0;
			end else begin
				addr_q <= addr_q + 32'd4;
				beats_left <= beats_left - 8'd1;
				rvalid <= ready_draw();
			end
		end else if (!rvalid) begin
			// a raised rvalid stays up until the beat is taken
			rvalid <= ready_draw();
		end
	end

endmodule

/* testbench/tb_fetch_mem.sv */
// table-driven testbench for the fetch cache, uncached I/O reader and read arbiter
`timescale 1ns/1ns
`include "fetch_params.svh"

module tb_fetch_mem;

	localparam int RESET_CYCLES = 16;
	localparam int CYCLES_PER_ENTRY = 200;
	localparam int WAIT_LIMIT = 150;
	localparam int PORT_FETCH = 0;
	localparam int PORT_IO = 1;
	localparam int PORT_BOTH = 2;

	typedef struct {
		string name;
		int port;
		fetch_pkg::addr_t addr;
		logic fence;
		logic hit;
	} entry_t;

	logic clock;
	logic reset;
	fetch_pkg::addr_t fetch_paddr;
	logic fetch_psel;
	logic fetch_fence;
	logic fetch_pready;
	fetch_pkg::word_t fetch_prdata;
	fetch_pkg::addr_t io_paddr;
	logic io_psel;
	logic io_pready;
	fetch_pkg::word_t io_prdata;
	logic m_arvalid;
	fetch_pkg::ar_req_t m_ar;
	logic m_arready;
	logic m_rvalid;
	fetch_pkg::r_beat_t m_r;
	logic m_rready;

	entry_t entries[$];
	fetch_pkg::ar_req_t ar_log[$];
	logic burst_open = 1'b0;
	logic table_ready = 1'b0;

	fetch_mem_top DUT (
		.clock(clock),
		.reset(reset),
		.fetch_paddr(fetch_paddr),
		.fetch_psel(fetch_psel),
		.fetch_fence(fetch_fence),
		.fetch_pready(fetch_pready),
		.fetch_prdata(fetch_prdata),
		.io_paddr(io_paddr),
		.io_psel(io_psel),
		.io_pready(io_pready),
		.io_prdata(io_prdata),
		.m_arvalid(m_arvalid),
		.m_ar(m_ar),
		.m_arready(m_arready),
		.m_rvalid(m_rvalid),
		.m_r(m_r),
		.m_rready(m_rready)
	);

	axi_mem_model u_mem (
		.clock(clock),
		.reset(reset),
		.arvalid(m_arvalid),
		.ar(m_ar),
		.arready(m_arready),
		.rvalid(m_rvalid),
		.r(m_r),
		.rready(m_rready)
	);

	initial clock = 1'b0;
	always #10 clock = ~clock;

	task automatic abort_run(input string msg);
		$display("%s", msg);
		$display("TB FAILED");
		$fatal(1, "run stopped at first error");
	endtask

	task automatic check_word(input string name, input fetch_pkg::word_t exp,
			input fetch_pkg::word_t act);
		if (act !== exp) begin
			abort_run($sformatf("ERR %s: expected %h, actual %h", name, exp, act));
		end
	endtask

	task automatic check_ar(input string name, input fetch_pkg::ar_req_t exp,
			input fetch_pkg::ar_req_t act);
		if (act !== exp) begin
			abort_run($sformatf("ERR %s: expected ar %h, actual ar %h", name, exp, act));
		end
	endtask

	task automatic check_count(input string name, input int exp, input int act);
		if (act != exp) begin
			abort_run($sformatf("ERR %s: expected %0d, actual %0d", name, exp, act));
		end
	endtask

	// memory rule applied to any byte address
	function automatic fetch_pkg::word_t mem_word(input fetch_pkg::addr_t addr);
		mem_word = (addr & ~32'h3) ^ 32'h5A5A_0000;
	endfunction

	task automatic add_entry(input string name, input int port, input fetch_pkg::addr_t addr,
			input logic fence, input logic hit);
		entry_t e;
		e.name = name;
		e.port = port;
		e.addr = addr;
		e.fence = fence;
		e.hit = hit;
		entries.push_back(e);
	endtask

	task automatic load_table();
		add_entry("first_miss", PORT_FETCH, 32'h0000_0104, 1'b0, 1'b0);
		add_entry("same_line_hit", PORT_FETCH, 32'h0000_010C, 1'b0, 1'b1);
		add_entry("other_line_miss", PORT_FETCH, 32'h0000_0238, 1'b0, 1'b0);
		add_entry("other_line_hit", PORT_FETCH, 32'h0000_0230, 1'b0, 1'b1);
		add_entry("fence_refill", PORT_FETCH, 32'h0000_0108, 1'b1, 1'b0);
		add_entry("fence_refill_hit", PORT_FETCH, 32'h0000_0100, 1'b0, 1'b1);
		// index 0 with two tags
		add_entry("evict_a", PORT_FETCH, 32'h0000_0480, 1'b0, 1'b0);
		add_entry("evict_b", PORT_FETCH, 32'h0000_0104, 1'b0, 1'b0);
		add_entry("evict_a_again", PORT_FETCH, 32'h0000_048C, 1'b0, 1'b0);
		add_entry("evict_b_again", PORT_FETCH, 32'h0000_0100, 1'b0, 1'b0);
		add_entry("io_read_1", PORT_IO, 32'h1000_0046, 1'b0, 1'b0);
		add_entry("io_read_2", PORT_IO, 32'h1000_0046, 1'b0, 1'b0);
		add_entry("io_read_3", PORT_IO, 32'h1000_0046, 1'b0, 1'b0);
		add_entry("both_miss", PORT_BOTH, 32'h0000_0750, 1'b0, 1'b0);
		add_entry("both_hit", PORT_BOTH, 32'h0000_0754, 1'b0, 1'b1);
		add_entry("both_miss_2", PORT_BOTH, 32'h0000_03F8, 1'b0, 1'b0);
	endtask

	// memory port monitor sampled mid-cycle where everything is settled
	always @(negedge clock) begin
		if (!reset) begin
			if (m_rvalid && m_rready && m_r.last) begin
				burst_open = 1'b0;
			end
			if (m_arvalid && burst_open) begin
				abort_run("memory port raised a new request before the last beat");
			end
			if (m_arvalid && m_arready) begin
				ar_log.push_back(m_ar);
				burst_open = 1'b1;
			end
		end
	end

	task automatic pulse_fence();
		@(posedge clock);
		#2;
		fetch_fence = 1'b1;
		@(posedge clock);
		#2;
		fetch_fence = 1'b0;
		@(posedge clock);
	endtask

	task automatic fetch_access(input string name, input fetch_pkg::addr_t addr, input logic hit);
		int cycles;
		fetch_pkg::word_t data;
		@(posedge clock);
		#2;
		fetch_paddr = addr;
		fetch_psel = 1'b1;
		cycles = 0;
		do begin
			@(posedge clock);
			#1;
			cycles++;
			if (cycles > WAIT_LIMIT) begin
				abort_run($sformatf("%s: fetch port never raised pready", name));
			end
		end while (!fetch_pready);
		data = fetch_prdata;
		#1;
		fetch_psel = 1'b0;
		check_word(name, mem_word(addr), data);
		if (hit) begin
			check_count($sformatf("%s hit latency", name), 2, cycles);
		end
	endtask

	task automatic io_access(input string name, input fetch_pkg::addr_t addr);
		int cycles;
		fetch_pkg::word_t data;
		@(posedge clock);
		#2;
		io_paddr = addr;
		io_psel = 1'b1;
		cycles = 0;
		do begin
			@(posedge clock);
			#1;
			cycles++;
			if (cycles > WAIT_LIMIT) begin
				abort_run($sformatf("%s: I/O port never raised pready", name));
			end
		end while (!io_pready);
		data = io_prdata;
		#1;
		io_psel = 1'b0;
		check_word($sformatf("%s io", name), mem_word(addr), data);
	endtask

	// with both ports busy the len tells a refill from an I/O read
	task automatic check_requests(input entry_t e, input fetch_pkg::addr_t io_addr);
		fetch_pkg::ar_req_t fetch_exp;
		fetch_pkg::ar_req_t io_exp;
		int expected_count;
		fetch_exp.addr = e.addr & ~32'hF;
		fetch_exp.len = 8'd3;
		fetch_exp.size = `AXI_SIZE_4;
		fetch_exp.burst = `AXI_BURST_INCR;
		io_exp.addr = io_addr & ~32'h3;
		io_exp.len = 8'd0;
		io_exp.size = `AXI_SIZE_4;
		io_exp.burst = `AXI_BURST_INCR;
		expected_count = 0;
		if (e.port != PORT_IO && !e.hit) begin
			expected_count++;
		end
		if (e.port != PORT_FETCH) begin
			expected_count++;
		end
		check_count($sformatf("%s request count", e.name), expected_count, ar_log.size());
		foreach (ar_log[j]) begin
			if (e.port == PORT_IO || (e.port == PORT_BOTH && ar_log[j].len == 8'd0)) begin
				check_ar(e.name, io_exp, ar_log[j]);
			end else begin
				check_ar(e.name, fetch_exp, ar_log[j]);
			end
		end
	endtask

	initial begin
		fetch_pkg::addr_t io_addr;
		reset = 1'b1;
		fetch_paddr = '0;
		fetch_psel = 1'b0;
		fetch_fence = 1'b0;
		io_paddr = '0;
		io_psel = 1'b0;
		load_table();
		table_ready = 1'b1;
		repeat (RESET_CYCLES) @(posedge clock);
		#2;
		reset = 1'b0;
		foreach (entries[i]) begin
			ar_log.delete();
			// concurrent I/O reads go to the device region at the same low offset
			if (entries[i].port == PORT_BOTH) begin
				io_addr = `FETCH_IO_BASE | {16'h0, entries[i].addr[15:0]};
			end else begin
				io_addr = entries[i].addr;
			end
			if (entries[i].fence) begin
				pulse_fence();
			end
			case (entries[i].port)
				PORT_FETCH: fetch_access(entries[i].name, entries[i].addr, entries[i].hit);
				PORT_IO: io_access(entries[i].name, io_addr);
				default: begin
					fork
						fetch_access(entries[i].name, entries[i].addr, entries[i].hit);
						io_access(entries[i].name, io_addr);
					join
				end
			endcase
			check_requests(entries[i], io_addr);
		end
		repeat (2) @(posedge clock);
		$display("TB PASSED");
		$finish;
	end

	// watchdog sized from the table length
	initial begin
		wait (table_ready);
		repeat (RESET_CYCLES + entries.size() * CYCLES_PER_ENTRY) @(posedge clock);
		abort_run("watchdog expired before all table entries finished");
	end

endmodule

/* fetch_mem_top.f */
+incdir+common
common/fetch_pkg.sv
icache/icache.sv
rtl/uncached_fetch.sv
rtl/axi_read_arbiter.sv
rtl/fetch_mem_top.sv
testbench/axi_mem_model.sv
testbench/tb_fetch_mem.sv
